// ==== tb.f ====
common/csr_pkg.sv
rtl/csr_access.sv
trap/trap_ctrl.sv
trap/irq_ctrl.sv
rtl/csr_counters.sv
rtl/csr_bank_top.sv
dv/csr_bank_tb.sv

// ==== Bender.yml ====
package:
  name: csr_bank

sources:
  - common/csr_pkg.sv
  - rtl/csr_access.sv
  - trap/trap_ctrl.sv
  - trap/irq_ctrl.sv
  - rtl/csr_counters.sv
  - rtl/csr_bank_top.sv
  - target: simulation
    files:
      - dv/csr_bank_tb.sv

// ==== dv/csr_bank_tb.sv ====
// Testbench for the CSR bank: clock, reset, stimulus, reference rules, checks and watchdog
`timescale 1ns/100ps

module csr_bank_tb;

    localparam bit          COMPRESSED   = 1'b1;
    localparam bit          MULDIV_EN    = 1'b1;
    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          SAMPLE_DELAY = 30;
    localparam int          TEST_CYCLES  = 400;     // Whole sequence needs about 150
    localparam logic [31:0] RAND_SEED    = 32'hb446d9b0;

    logic        clk = 1'b0;
    logic        reset_n, read_en_i, write_en_i, killed_i, hold_i;
    logic [1:0]  op_i;
    logic [11:0] addr_i;
    logic [31:0] wdata_i, pc_i, instruction_i, jump_target_i, irq_i;
    logic        raise_exception_i, instruction_compressed_i, jump_i;
    logic        machine_return_i, interrupt_ack_i;
    logic [4:0]  exception_code_i;
    logic [31:0] rdata_o, mepc_o, mtvec_o;
    logic        interrupt_pending_o;
    logic [1:0]  privilege_o;

    csr_bank_top #(
        .COMPRESSED (COMPRESSED),
        .MULDIV_EN  (MULDIV_EN)
    ) dut_i (
        .clk, .reset_n, .read_en_i, .write_en_i, .op_i, .addr_i, .wdata_i, .killed_i,
        .raise_exception_i, .exception_code_i, .pc_i, .instruction_i,
        .instruction_compressed_i, .jump_i, .jump_target_i, .machine_return_i,
        .interrupt_ack_i, .irq_i, .hold_i, .rdata_o, .interrupt_pending_o,
        .privilege_o, .mepc_o, .mtvec_o
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        $display("tests failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else fail_value(name, got, exp);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic csr_write(input logic [1:0] op, input logic [11:0] addr,
                             input logic [31:0] data);
        write_en_i = 1'b1;
        op_i       = op;
        addr_i     = addr;
        wdata_i    = data;
        next_cycle();
        write_en_i = 1'b0;
    endtask

    // Sampled mid-cycle, one cycle per read
    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        read_en_i = 1'b1;
        addr_i    = addr;
        #(SAMPLE_DELAY);
        data = rdata_o;
        next_cycle();
        read_en_i = 1'b0;
    endtask

    // Masked merge rule for write, set and clear
    function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] old,
                                             input logic [31:0] data,
                                             input logic [31:0] mask);
        logic [31:0] res;
        case (op)
            csr_pkg::OP_WRITE: res = (old & ~mask) | (data & mask);
            csr_pkg::OP_SET:   res = old | (data & mask);
            default:           res = old & ~(data & mask);
        endcase
        return res;
    endfunction

    function automatic logic [4:0] top_irq(input logic [31:0] lines);
        logic [4:0] code;
        code = 5'd0;
        if (lines[11]) begin
            code = 5'd11;   // External
        end else if (lines[3]) begin
            code = 5'd3;    // Software
        end else if (lines[7]) begin
            code = 5'd7;    // Timer
        end
        return code;
    endfunction

    task automatic check_exception(input logic [4:0] code, input logic old_mie);
        logic [31:0] pc, instr, rd;
        pc    = $urandom() & 32'hFFFF_FFFC;
        instr = $urandom();
        raise_exception_i = 1'b1;
        exception_code_i  = code;
        pc_i              = pc;
        instruction_i     = instr;
        next_cycle();
        raise_exception_i = 1'b0;
        expect_eq("privilege_o", {30'b0, privilege_o}, 32'd3);
        csr_read(csr_pkg::ADDR_MEPC, rd);
        expect_eq("mepc", rd, pc);
        csr_read(csr_pkg::ADDR_MCAUSE, rd);
        expect_eq("mcause", rd, {27'b0, code});
        csr_read(csr_pkg::ADDR_MTVAL, rd);
        expect_eq("mtval", rd, (code == 5'd2) ? instr : pc);
        csr_read(csr_pkg::ADDR_MSTATUS, rd);
        expect_eq("mstatus.MPIE", {31'b0, rd[7]}, {31'b0, old_mie});
        expect_eq("mstatus.MIE", {31'b0, rd[3]}, 32'h0);
    endtask

    task automatic irq_round(input logic [31:0] lines, input logic jump,
                             input logic compressed);
        logic [31:0] pc, target, rd, exp_epc;
        csr_write(csr_pkg::OP_SET, csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        irq_i = lines;
        next_cycle();   // mip takes the lines
        expect_eq("interrupt_pending_o", {31'b0, interrupt_pending_o}, 32'h0);
        next_cycle();
        expect_eq("interrupt_pending_o", {31'b0, interrupt_pending_o}, 32'h1);
        pc     = $urandom() & 32'hFFFF_FFFC;
        target = $urandom() & 32'hFFFF_FFFC;
        irq_i                    = '0;
        interrupt_ack_i          = 1'b1;
        jump_i                   = jump;
        jump_target_i            = target;
        pc_i                     = pc;
        instruction_compressed_i = compressed;
        next_cycle();
        interrupt_ack_i          = 1'b0;
        jump_i                   = 1'b0;
        instruction_compressed_i = 1'b0;
        expect_eq("interrupt_pending_o", {31'b0, interrupt_pending_o}, 32'h0);
        exp_epc = jump ? target : pc + (compressed ? 32'd2 : 32'd4);
        csr_read(csr_pkg::ADDR_MCAUSE, rd);
        expect_eq("mcause", rd, {1'b1, 26'b0, top_irq(lines & 32'h0000_0888)});
        csr_read(csr_pkg::ADDR_MEPC, rd);
        expect_eq("mepc", rd, exp_epc);
        expect_eq("mepc_o", mepc_o, exp_epc);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd, wd, c0, c1, ref_mscratch, ref_mie, exp_mtvec;
        logic [1:0]  op;
        int          n;
        int          seed_ret;
        seed_ret                 = $urandom(RAND_SEED);
        reset_n                  = 1'b0;
        {read_en_i, write_en_i, killed_i, hold_i} = '0;
        op_i                     = '0;
        addr_i                   = '0;
        wdata_i                  = '0;
        raise_exception_i        = 1'b0;
        exception_code_i         = '0;
        pc_i                     = '0;
        instruction_i            = '0;
        instruction_compressed_i = 1'b0;
        jump_i                   = 1'b0;
        jump_target_i            = '0;
        machine_return_i         = 1'b0;
        interrupt_ack_i          = 1'b0;
        irq_i                    = '0;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        reset_n = 1'b1;

        // Reset state
        expect_eq("privilege_o", {30'b0, privilege_o}, 32'd3);
        expect_eq("interrupt_pending_o", {31'b0, interrupt_pending_o}, 32'h0);
        csr_read(csr_pkg::ADDR_MSTATUS, rd);
        expect_eq("mstatus", rd, 32'h0000_1800);
        csr_read(csr_pkg::ADDR_MTVEC, rd);
        expect_eq("mtvec", rd, 32'h0);
        csr_read(csr_pkg::ADDR_MEPC, rd);
        expect_eq("mepc", rd, 32'h0);
        csr_read(csr_pkg::ADDR_MCAUSE, rd);
        expect_eq("mcause", rd, 32'h0);
        csr_read(csr_pkg::ADDR_MISA, rd);
        expect_eq("misa", rd, 32'h4000_0100 | (32'(MULDIV_EN) << 12) | (32'(COMPRESSED) << 2));

        // Trap vector keeps only aligned bits
        exp_mtvec = 32'h8000_0107 & (COMPRESSED ? 32'hFFFF_FFFE : 32'hFFFF_FFFC);
        csr_write(csr_pkg::OP_WRITE, csr_pkg::ADDR_MTVEC, 32'h8000_0107);
        expect_eq("mtvec_o", mtvec_o, exp_mtvec);
        csr_read(csr_pkg::ADDR_MTVEC, rd);
        expect_eq("mtvec", rd, exp_mtvec);

        // Masked operations on mscratch and mie
        ref_mscratch = '0;
        ref_mie      = '0;
        repeat (16) begin
            case ($urandom_range(0, 2))
                0:       op = csr_pkg::OP_WRITE;
                1:       op = csr_pkg::OP_SET;
                default: op = csr_pkg::OP_CLEAR;
            endcase
            wd = $urandom();
            if ($urandom_range(0, 1) == 0) begin
                csr_write(op, csr_pkg::ADDR_MSCRATCH, wd);
                ref_mscratch = apply_op(op, ref_mscratch, wd, 32'hFFFF_FFFF);
            end else begin
                csr_write(op, csr_pkg::ADDR_MIE, wd);
                ref_mie = apply_op(op, ref_mie, wd, 32'h0000_0888);
            end
            csr_read(csr_pkg::ADDR_MSCRATCH, rd);
            expect_eq("mscratch", rd, ref_mscratch);
            csr_read(csr_pkg::ADDR_MIE, rd);
            expect_eq("mie", rd, ref_mie);
        end
        killed_i = 1'b1;
        csr_write(csr_pkg::OP_WRITE, csr_pkg::ADDR_MSCRATCH, ~ref_mscratch);
        csr_write(csr_pkg::OP_WRITE, csr_pkg::ADDR_MIE, ~ref_mie);
        killed_i = 1'b0;
        csr_read(csr_pkg::ADDR_MSCRATCH, rd);
        expect_eq("mscratch", rd, ref_mscratch);
        csr_read(csr_pkg::ADDR_MIE, rd);
        expect_eq("mie", rd, ref_mie);
        addr_i = csr_pkg::ADDR_MISA;   // read_en_i stays low
        #(SAMPLE_DELAY);
        expect_eq("rdata_o", rdata_o, 32'h0);
        next_cycle();

        // Exception entry, first with MIE set
        csr_write(csr_pkg::OP_SET, csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        check_exception(5'd2, 1'b1);
        check_exception(5'd5, 1'b0);

        // Interrupt priority and entry
        csr_write(csr_pkg::OP_WRITE, csr_pkg::ADDR_MIE, 32'h0000_0888);
        irq_round(32'h0000_0088, 1'b0, 1'b0);
        irq_round(32'h0001_0888, 1'b1, 1'b0);
        irq_round(32'h0000_0080, 1'b0, 1'b1);

        // Machine return to user mode
        csr_write(csr_pkg::OP_WRITE, csr_pkg::ADDR_MSTATUS, 32'h0000_0080);
        machine_return_i = 1'b1;
        next_cycle();
        machine_return_i = 1'b0;
        expect_eq("privilege_o", {30'b0, privilege_o}, 32'd0);
        csr_read(csr_pkg::ADDR_MSTATUS, rd);
        expect_eq("mstatus.MIE", {31'b0, rd[3]}, 32'h1);
        check_exception(5'd5, 1'b1);   // Trap taken from user mode

        // Counters
        n = $urandom_range(1, 16);
        csr_read(csr_pkg::ADDR_MCYCLE, c0);
        repeat (n - 1) next_cycle();
        csr_read(csr_pkg::ADDR_MCYCLE, c1);
        expect_eq("mcycle (difference)", c1 - c0, 32'(n));

        hold_i = 1'b1;
        csr_read(csr_pkg::ADDR_MINSTRET, c0);
        repeat ($urandom_range(1, 16)) begin
            case ($urandom_range(0, 2))
                0:       {killed_i, hold_i} = 2'b10;
                1:       {killed_i, hold_i} = 2'b01;
                default: {killed_i, hold_i} = 2'b11;
            endcase
            next_cycle();
        end
        {killed_i, hold_i} = 2'b01;
        csr_read(csr_pkg::ADDR_MINSTRET, c1);
        hold_i = 1'b0;
        expect_eq("minstret", c1, c0);
        next_cycle();   // One retiring cycle
        csr_read(csr_pkg::ADDR_INSTRET, rd);
        expect_eq("instret", rd, c1 + 32'd1);

        wd = $urandom();
        csr_write(csr_pkg::OP_WRITE, csr_pkg::ADDR_MCYCLEH, wd);
        csr_read(csr_pkg::ADDR_CYCLEH, rd);
        expect_eq("cycleh", rd, wd);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== rtl/csr_bank_top.sv ====
// Machine-mode CSR bank top: access, trap, interrupt and counter blocks
`timescale 1ns/100ps

module csr_bank_top #(
    parameter bit COMPRESSED = 1'b1,
    parameter bit MULDIV_EN  = 1'b1
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            read_en_i,
    input  logic                            write_en_i,
    input  logic [1:0]                      op_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_i,
    input  logic [31:0]                     wdata_i,
    input  logic                            killed_i,
    input  logic                            raise_exception_i,
    input  logic [4:0]                      exception_code_i,
    input  logic [31:0]                     pc_i,
    input  logic [31:0]                     instruction_i,
    input  logic                            instruction_compressed_i,
    input  logic                            jump_i,
    input  logic [31:0]                     jump_target_i,
    input  logic                            machine_return_i,
    input  logic                            interrupt_ack_i,
    input  logic [31:0]                     irq_i,
    input  logic                            hold_i,
    output logic [31:0]                     rdata_o,
    output logic                            interrupt_pending_o,
    output logic [1:0]                      privilege_o,
    output logic [31:0]                     mepc_o,
    output logic [31:0]                     mtvec_o
);

    csr_pkg::csr_mstatus_u mstatus;
    logic [31:0] mcause, mtval, mip, mie, wr_data;
    logic [63:0] mcycle, minstret;
    logic        mstatus_we, mepc_we, mcause_we, mtval_we;
    logic        mcycle_lo_we, mcycle_hi_we, minstret_lo_we, minstret_hi_we;
    logic [4:0]  irq_cause;

    wire trap_event = machine_return_i | raise_exception_i | interrupt_ack_i; // Blocks CSR writes

    csr_access #(
        .COMPRESSED (COMPRESSED),
        .MULDIV_EN  (MULDIV_EN)
    ) access_i (
        .clk, .reset_n, .read_en_i, .write_en_i, .killed_i, .op_i, .addr_i, .wdata_i,
        .trap_event_i     (trap_event),
        .mstatus_i        (mstatus),
        .mepc_i           (mepc_o),
        .mcause_i         (mcause),
        .mtval_i          (mtval),
        .mip_i            (mip),
        .mcycle_i         (mcycle),
        .minstret_i       (minstret),
        .rdata_o          (rdata_o),
        .wr_data_o        (wr_data),
        .mstatus_we_o     (mstatus_we),
        .mepc_we_o        (mepc_we),
        .mcause_we_o      (mcause_we),
        .mtval_we_o       (mtval_we),
        .mcycle_lo_we_o   (mcycle_lo_we),
        .mcycle_hi_we_o   (mcycle_hi_we),
        .minstret_lo_we_o (minstret_lo_we),
        .minstret_hi_we_o (minstret_hi_we),
        .mie_o            (mie),
        .mtvec_o          (mtvec_o)
    );

    trap_ctrl #(.COMPRESSED(COMPRESSED)) trap_i (
        .clk, .reset_n, .machine_return_i, .raise_exception_i, .exception_code_i,
        .interrupt_ack_i, .pc_i, .instruction_i, .instruction_compressed_i,
        .jump_i, .jump_target_i,
        .wr_data_i    (wr_data),
        .mstatus_we_i (mstatus_we),
        .mepc_we_i    (mepc_we),
        .mcause_we_i  (mcause_we),
        .mtval_we_i   (mtval_we),
        .irq_cause_i  (irq_cause),
        .mstatus_o    (mstatus),
        .mepc_o       (mepc_o),
        .mcause_o     (mcause),
        .mtval_o      (mtval),
        .privilege_o  (privilege_o)
    );

    irq_ctrl irq_i_ctrl (
        .clk, .reset_n, .irq_i, .interrupt_ack_i,
        .mie_i               (mie),
        .global_ie_i         (mstatus.f.mie),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_cause_o         (irq_cause)
    );

    csr_counters counters_i (
        .clk, .reset_n, .killed_i, .hold_i,
        .wr_data_i        (wr_data),
        .mcycle_lo_we_i   (mcycle_lo_we),
        .mcycle_hi_we_i   (mcycle_hi_we),
        .minstret_lo_we_i (minstret_lo_we),
        .minstret_hi_we_i (minstret_hi_we),
        .mcycle_o         (mcycle),
        .minstret_o       (minstret)
    );

endmodule

// ==== rtl/csr_counters.sv ====
// 64-bit mcycle and minstret counters with CSR half-word writes
`timescale 1ns/100ps

module csr_counters (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        killed_i,
    input  logic                        hold_i,
    input  logic [csr_pkg::XLEN-1:0]    wr_data_i,
    input  logic                        mcycle_lo_we_i,
    input  logic                        mcycle_hi_we_i,
    input  logic                        minstret_lo_we_i,
    input  logic                        minstret_hi_we_i,
    output logic [63:0]                 mcycle_o,
    output logic [63:0]                 minstret_o
);

    // A half written by a CSR access replaces the increment
    function automatic logic [63:0] next_count(input logic [63:0] cnt, input logic inc,
                                               input logic lo_we, input logic hi_we,
                                               input logic [31:0] data);
        logic [63:0] nxt;
        nxt = cnt + 64'(inc);
        if (lo_we) begin
            nxt = {cnt[63:32], data};
        end
        if (hi_we) begin
            nxt = {data, cnt[31:0]};
        end
        return nxt;
    endfunction

    logic retire;

    assign retire = ~killed_i & ~hold_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= next_count(mcycle_o, 1'b1, mcycle_lo_we_i, mcycle_hi_we_i,
                                     wr_data_i);
            minstret_o <= next_count(minstret_o, retire, minstret_lo_we_i,
                                     minstret_hi_we_i, wr_data_i);
        end
    end

endmodule

// ==== trap/irq_ctrl.sv ====
// Interrupt sampling into mip, pending flag and fixed-priority cause select
`timescale 1ns/100ps

module irq_ctrl (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [csr_pkg::XLEN-1:0]    irq_i,
    input  logic [csr_pkg::XLEN-1:0]    mie_i,
    input  logic                        global_ie_i,
    input  logic                        interrupt_ack_i,
    output logic [csr_pkg::XLEN-1:0]    mip_o,
    output logic                        interrupt_pending_o,
    output logic [4:0]                  irq_cause_o
);

    logic [31:0] active;

    assign active = mie_i & mip_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i; // One edge of sampling delay
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            interrupt_pending_o <= 1'b0;
            irq_cause_o         <= '0;
        end else if (global_ie_i && (active != '0) && !interrupt_ack_i) begin
            interrupt_pending_o <= 1'b1;
            if (active[csr_pkg::IRQ_M_EXT]) begin
                irq_cause_o <= csr_pkg::IRQ_M_EXT;
            end else if (active[csr_pkg::IRQ_M_SOFT]) begin
                irq_cause_o <= csr_pkg::IRQ_M_SOFT;
            end else if (active[csr_pkg::IRQ_M_TIMER]) begin
                irq_cause_o <= csr_pkg::IRQ_M_TIMER;
            end
        end else begin
            interrupt_pending_o <= 1'b0; // Ack or nothing enabled
        end
    end

endmodule

// ==== trap/trap_ctrl.sv ====
// Trap state: mstatus, mepc, mcause, mtval and privilege with trap and return updates
`timescale 1ns/100ps

module trap_ctrl #(
    parameter bit COMPRESSED = 1'b1
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [csr_pkg::XLEN-1:0]    wr_data_i,
    input  logic                        mstatus_we_i,
    input  logic                        mepc_we_i,
    input  logic                        mcause_we_i,
    input  logic                        mtval_we_i,
    input  logic                        machine_return_i,
    input  logic                        raise_exception_i,
    input  logic [4:0]                  exception_code_i,
    input  logic                        interrupt_ack_i,
    input  logic [4:0]                  irq_cause_i,
    input  logic [31:0]                 pc_i,
    input  logic [31:0]                 instruction_i,
    input  logic                        instruction_compressed_i,
    input  logic                        jump_i,
    input  logic [31:0]                 jump_target_i,
    output csr_pkg::csr_mstatus_u       mstatus_o,
    output logic [csr_pkg::XLEN-1:0]    mepc_o,
    output logic [csr_pkg::XLEN-1:0]    mcause_o,
    output logic [csr_pkg::XLEN-1:0]    mtval_o,
    output logic [1:0]                  privilege_o
);

    localparam logic [31:0] EPC_MASK = COMPRESSED ? 32'hFFFF_FFFE : 32'hFFFF_FFFC;

    logic [31:0] irq_epc;

    // Interrupted instruction retires, so return to the one after it
    assign irq_epc = jump_i ? jump_target_i
                            : pc_i + (instruction_compressed_i ? 32'd2 : 32'd4);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_o.raw   <= '0;
            mstatus_o.f.mpp <= csr_pkg::PRIV_M;
            mepc_o          <= '0;
            mcause_o        <= '0;
            mtval_o         <= '0;
            privilege_o     <= csr_pkg::PRIV_M;
        end else if (machine_return_i) begin
            mstatus_o.f.mie <= mstatus_o.f.mpie;
            privilege_o     <= mstatus_o.f.mpp;
        end else if (raise_exception_i) begin
            mstatus_o.f.mpp  <= privilege_o;
            mstatus_o.f.mpie <= mstatus_o.f.mie;
            mstatus_o.f.mie  <= 1'b0;
            privilege_o      <= csr_pkg::PRIV_M;
            mepc_o           <= pc_i & EPC_MASK;
            mcause_o         <= {27'b0, exception_code_i};
            mtval_o          <= (exception_code_i == csr_pkg::EXC_ILLEGAL_INSTR)
                                ? instruction_i
                                : pc_i;
        end else if (interrupt_ack_i) begin
            mstatus_o.f.mpp  <= privilege_o;
            mstatus_o.f.mpie <= mstatus_o.f.mie;
            mstatus_o.f.mie  <= 1'b0;
            privilege_o      <= csr_pkg::PRIV_M;
            mepc_o           <= irq_epc & EPC_MASK;
            mcause_o         <= {1'b1, 26'b0, irq_cause_i}; // Interrupt flag in top bit
        end else begin
            if (mstatus_we_i) begin
                mstatus_o.raw <= wr_data_i & csr_pkg::MASK_MSTATUS;
            end
            if (mepc_we_i) begin
                mepc_o <= wr_data_i;
            end
            if (mcause_we_i) begin
                mcause_o <= wr_data_i;
            end
            if (mtval_we_i) begin
                mtval_o <= wr_data_i;
            end
        end
    end

endmodule

// ==== rtl/csr_access.sv ====
// CSR address decode, masked write merge, write strobes, read mux, mie/mtvec/mscratch
`timescale 1ns/100ps

module csr_access #(
    parameter bit COMPRESSED = 1'b1,
    parameter bit MULDIV_EN  = 1'b1
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            read_en_i,
    input  logic                            write_en_i,
    input  logic                            killed_i,
    input  logic [1:0]                      op_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_i,
    input  logic [csr_pkg::XLEN-1:0]        wdata_i,
    input  logic                            trap_event_i,
    input  csr_pkg::csr_mstatus_u           mstatus_i,
    input  logic [csr_pkg::XLEN-1:0]        mepc_i,
    input  logic [csr_pkg::XLEN-1:0]        mcause_i,
    input  logic [csr_pkg::XLEN-1:0]        mtval_i,
    input  logic [csr_pkg::XLEN-1:0]        mip_i,
    input  logic [63:0]                     mcycle_i,
    input  logic [63:0]                     minstret_i,
    output logic [csr_pkg::XLEN-1:0]        rdata_o,
    output logic [csr_pkg::XLEN-1:0]        wr_data_o,
    output logic                            mstatus_we_o,
    output logic                            mepc_we_o,
    output logic                            mcause_we_o,
    output logic                            mtval_we_o,
    output logic                            mcycle_lo_we_o,
    output logic                            mcycle_hi_we_o,
    output logic                            minstret_lo_we_o,
    output logic                            minstret_hi_we_o,
    output logic [csr_pkg::XLEN-1:0]        mie_o,
    output logic [csr_pkg::XLEN-1:0]        mtvec_o
);

    localparam logic [31:0] ALIGN_MASK = COMPRESSED ? 32'hFFFF_FFFE : 32'hFFFF_FFFC;

    // MXL=1, M bit 12, I bit 8, C bit 2
    localparam logic [31:0] MISA_VALUE = {2'b01, 17'b0, MULDIV_EN, 3'b0, 1'b1, 5'b0,
                                          COMPRESSED, 2'b0};

    logic [31:0] cur_val, wmask, mscratch_q;
    logic        read_ok, write_ok;

    assign read_ok  = read_en_i & ~killed_i;
    assign write_ok = write_en_i & ~killed_i & ~trap_event_i; // Traps win over CSR writes

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (addr_i)
            csr_pkg::ADDR_MSTATUS:   cur_val = mstatus_i.raw;
            csr_pkg::ADDR_MISA:      cur_val = MISA_VALUE;
            csr_pkg::ADDR_MIE:       cur_val = mie_o;
            csr_pkg::ADDR_MTVEC:     cur_val = mtvec_o;
            csr_pkg::ADDR_MSCRATCH:  cur_val = mscratch_q;
            csr_pkg::ADDR_MEPC:      cur_val = mepc_i;
            csr_pkg::ADDR_MCAUSE:    cur_val = mcause_i;
            csr_pkg::ADDR_MTVAL:     cur_val = mtval_i;
            csr_pkg::ADDR_MIP:       cur_val = mip_i;
            csr_pkg::ADDR_MCYCLE,    csr_pkg::ADDR_CYCLE:    cur_val = mcycle_i[31:0];
            csr_pkg::ADDR_MCYCLEH,   csr_pkg::ADDR_CYCLEH:   cur_val = mcycle_i[63:32];
            csr_pkg::ADDR_MINSTRET,  csr_pkg::ADDR_INSTRET:  cur_val = minstret_i[31:0];
            csr_pkg::ADDR_MINSTRETH, csr_pkg::ADDR_INSTRETH: cur_val = minstret_i[63:32];
            csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID,
            csr_pkg::ADDR_MIMPID,    csr_pkg::ADDR_MHARTID:  cur_val = '0;
            default:                 cur_val = '0;
        endcase
    end

    // Read-only and unknown addresses keep a zero mask
    always_comb begin
        case (addr_i)
            csr_pkg::ADDR_MSTATUS:                       wmask = csr_pkg::MASK_MSTATUS;
            csr_pkg::ADDR_MIE:                           wmask = csr_pkg::MASK_MIE;
            csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MEPC:     wmask = ALIGN_MASK;
            csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MTVAL,
            csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_MINSTRETH: wmask = csr_pkg::MASK_FULL;
            default:                                     wmask = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            csr_pkg::OP_WRITE: wr_data_o = (cur_val & ~wmask) | (wdata_i & wmask);
            csr_pkg::OP_SET:   wr_data_o = cur_val | (wdata_i & wmask);
            csr_pkg::OP_CLEAR: wr_data_o = cur_val & ~(wdata_i & wmask);
            default:           wr_data_o = cur_val;
        endcase
    end

    assign rdata_o = read_ok ? cur_val : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Write strobes and local registers
    ////////////////////////////////////////////////////////////////////////////

    assign mstatus_we_o     = write_ok && (addr_i == csr_pkg::ADDR_MSTATUS);
    assign mepc_we_o        = write_ok && (addr_i == csr_pkg::ADDR_MEPC);
    assign mcause_we_o      = write_ok && (addr_i == csr_pkg::ADDR_MCAUSE);
    assign mtval_we_o       = write_ok && (addr_i == csr_pkg::ADDR_MTVAL);
    assign mcycle_lo_we_o   = write_ok && (addr_i == csr_pkg::ADDR_MCYCLE);
    assign mcycle_hi_we_o   = write_ok && (addr_i == csr_pkg::ADDR_MCYCLEH);
    assign minstret_lo_we_o = write_ok && (addr_i == csr_pkg::ADDR_MINSTRET);
    assign minstret_hi_we_o = write_ok && (addr_i == csr_pkg::ADDR_MINSTRETH);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mie_o      <= '0;
            mtvec_o    <= '0;
            mscratch_q <= '0;
        end else if (write_ok) begin
            case (addr_i)
                csr_pkg::ADDR_MIE:      mie_o      <= wr_data_o;
                csr_pkg::ADDR_MTVEC:    mtvec_o    <= wr_data_o;
                csr_pkg::ADDR_MSCRATCH: mscratch_q <= wr_data_o;
                default: ;
            endcase
        end
    end

endmodule

// ==== common/csr_pkg.sv ====
// CSR widths, addresses, operation codes, write masks, cause codes and the mstatus view
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // Machine trap setup and handling
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP       = 12'h344;

    // Counters and their user aliases
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRETH = 12'hB82;
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE     = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRET   = 12'hC02;
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLEH    = 12'hC80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRETH  = 12'hC82;

    // ID registers, all read as zero
    localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;

    localparam logic [1:0] OP_WRITE = 2'b01;
    localparam logic [1:0] OP_SET   = 2'b10;
    localparam logic [1:0] OP_CLEAR = 2'b11;

    localparam logic [XLEN-1:0] MASK_MSTATUS = 32'h0000_1888; // MPP, MPIE, MIE
    localparam logic [XLEN-1:0] MASK_MIE     = 32'h0000_0888;
    localparam logic [XLEN-1:0] MASK_FULL    = 32'hFFFF_FFFF;

    localparam logic [4:0] IRQ_M_SOFT        = 5'd3;
    localparam logic [4:0] IRQ_M_TIMER       = 5'd7;
    localparam logic [4:0] IRQ_M_EXT         = 5'd11;
    localparam logic [4:0] EXC_ILLEGAL_INSTR = 5'd2;

    localparam logic [1:0] PRIV_U = 2'b00;
    localparam logic [1:0] PRIV_M = 2'b11;

    // Raw CSR word or the trap fields of mstatus
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [18:0] pad_31_13;
            logic [1:0]  mpp;
            logic [2:0]  pad_10_8;
            logic        mpie;
            logic [2:0]  pad_6_4;
            logic        mie;
            logic [2:0]  pad_2_0;
        } f;
    } csr_mstatus_u;

endpackage
